// ==== bus_arbiter.sv ====
// Round-robin bus arbiter
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic                                clock,
	input  logic                                reset,
	input  domain_pkg::dom_req_t                requests [domain_pkg::num_master],
	input  logic [domain_pkg::num_master-1:0]   eligible,
	input  logic [domain_pkg::num_master-1:0]   done,
	input  domain_pkg::wb_req_t                 master_req [domain_pkg::num_master],
	output domain_pkg::wb_rsp_t                 master_rsp [domain_pkg::num_master],
	output domain_pkg::wb_req_t                 slave_req,
	input  domain_pkg::wb_rsp_t                 slave_rsp,
	output logic [domain_pkg::num_master-1:0]   grant,
	output logic                                grant_valid,
	output logic [domain_pkg::master_w-1:0]     grant_no
);
	import domain_pkg::*;

	logic [num_master-1:0]  req_vec;
	logic [num_master-1:0]  cyc_vec;  // Masters in a bus cycle
	logic [master_w-1:0]    last_no;  // Previous winner
	logic [master_w-1:0]    cand;
	logic [master_w-1:0]    pick;
	logic                   found;

	always_comb begin
		for (int m = 0; m < num_master; m++) begin
			req_vec[m] = requests[m].pending & eligible[m];
			cyc_vec[m] = master_req[m].cyc;
		end
	end

	// Search starts just after the last winner
	always_comb begin
		pick  = last_no;
		found = 1'b0;
		cand  = last_no;
		for (int i = 1; i <= num_master; i++) begin
			cand = last_no + master_w'(i);
			if (!found && req_vec[cand]) begin
				pick  = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			grant       <= '0;
			grant_valid <= 1'b0;
			grant_no    <= '0;
			last_no     <= master_w'(num_master - 1);  // Master 0 first
		end else if (grant_valid) begin
			if (done[grant_no]) begin  // Block finished
				grant       <= '0;
				grant_valid <= 1'b0;
			end
		end else if (found) begin
			grant       <= '0;
			grant[pick] <= 1'b1;
			grant_valid <= 1'b1;
			grant_no    <= pick;
			last_no     <= pick;
		end
	end

	////////////////////////////////////////
	// Bus multiplexer
	assign slave_req = grant_valid ? master_req[grant_no] : '0;

	always_comb begin
		for (int m = 0; m < num_master; m++) begin
			master_rsp[m].ack = slave_rsp.ack & grant[m];
			master_rsp[m].dat = slave_rsp.dat;
		end
	end

	// Bus cycles only from the master holding the grant
	assert property (@(posedge clock) disable iff (reset)
		(cyc_vec & ~grant) == '0);

endmodule

`default_nettype wire

// ==== domain_pkg.sv ====
// Domain transfer fabric
// Shared widths and bus types
`default_nettype none

package domain_pkg;

	////////////////////////////////////////
	// Sizes
	localparam int addr_w     = 16;  // Word address
	localparam int data_w     = 32;
	localparam int block_len  = 8;   // Words per block
	localparam int cnt_w      = 3;   // Word counter
	localparam int num_domain = 4;   // Tracker entries
	localparam int entry_w    = 2;
	localparam int num_engine = 2;   // Per kind
	localparam int num_master = 4;   // Stores 0,1 then loads 2,3
	localparam int master_w   = 2;
	localparam int mem_aw     = 8;   // Memory index bits

	////////////////////////////////////////
	// Bus and handshake types
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [addr_w-1:0] adr;
		logic [data_w-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [data_w-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic              pending;  // Block wanted
		logic              store;    // Store or load
		logic [addr_w-1:0] base;
	} dom_req_t;

	typedef struct packed {
		logic [addr_w-1:0] base;
		logic [data_w-1:0] seed;
	} store_cmd_t;

	typedef struct packed {
		logic [addr_w-1:0] base;
		logic [data_w-1:0] sum;
	} load_result_t;

endpackage

`default_nettype wire

// ==== domain_top.sv ====
// Block transfer fabric top
`timescale 1ns/1ps
`default_nettype none

module domain_top (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic [domain_pkg::num_engine-1:0]     store_cmd_valid,
	input  domain_pkg::store_cmd_t                store_cmd [domain_pkg::num_engine],
	output logic [domain_pkg::num_engine-1:0]     store_cmd_ready,
	input  logic [domain_pkg::num_engine-1:0]     load_cmd_valid,
	input  logic [domain_pkg::addr_w-1:0]         load_cmd_base [domain_pkg::num_engine],
	output logic [domain_pkg::num_engine-1:0]     load_cmd_ready,
	output logic [domain_pkg::num_engine-1:0]     load_res_valid,
	output domain_pkg::load_result_t              load_res [domain_pkg::num_engine]
);
	import domain_pkg::*;

	dom_req_t               requests [num_master];
	wb_req_t                master_req [num_master];
	wb_rsp_t                master_rsp [num_master];
	wb_req_t                slave_req;
	wb_rsp_t                slave_rsp;
	logic [num_master-1:0]  done;
	logic [num_master-1:0]  eligible;
	logic [num_master-1:0]  grant;
	logic                   grant_valid;
	logic [master_w-1:0]    grant_no;

	////////////////////////////////////////
	// Engines, stores first
	for (genvar i = 0; i < num_engine; i++) begin : g_store
		store_engine u_store (
			.clock     (clock),
			.reset     (reset),
			.cmd_valid (store_cmd_valid[i]),
			.cmd       (store_cmd[i]),
			.cmd_ready (store_cmd_ready[i]),
			.request   (requests[i]),
			.grant     (grant[i]),
			.wb_req    (master_req[i]),
			.wb_rsp    (master_rsp[i]),
			.done      (done[i])
		);
	end

	for (genvar i = 0; i < num_engine; i++) begin : g_load
		load_engine u_load (
			.clock     (clock),
			.reset     (reset),
			.cmd_valid (load_cmd_valid[i]),
			.cmd_base  (load_cmd_base[i]),
			.cmd_ready (load_cmd_ready[i]),
			.request   (requests[i + num_engine]),
			.grant     (grant[i + num_engine]),
			.wb_req    (master_req[i + num_engine]),
			.wb_rsp    (master_rsp[i + num_engine]),
			.done      (done[i + num_engine]),
			.res_valid (load_res_valid[i]),
			.result    (load_res[i])
		);
	end

	////////////////////////////////////////
	// Control and shared bus
	domain_tracker u_tracker (
		.clock       (clock),
		.reset       (reset),
		.requests    (requests),
		.grant_valid (grant_valid),
		.grant_no    (grant_no),
		.done        (done),
		.eligible    (eligible)
	);

	bus_arbiter u_arbiter (
		.clock       (clock),
		.reset       (reset),
		.requests    (requests),
		.eligible    (eligible),
		.done        (done),
		.master_req  (master_req),
		.master_rsp  (master_rsp),
		.slave_req   (slave_req),
		.slave_rsp   (slave_rsp),
		.grant       (grant),
		.grant_valid (grant_valid),
		.grant_no    (grant_no)
	);

	shared_memory u_memory (
		.clock  (clock),
		.reset  (reset),
		.wb_req (slave_req),
		.wb_rsp (slave_rsp)
	);

endmodule

`default_nettype wire

// ==== domain_tracker.sv ====
// Domain tracker
`timescale 1ns/1ps
`default_nettype none

module domain_tracker (
	input  logic                                clock,
	input  logic                                reset,
	input  domain_pkg::dom_req_t                requests [domain_pkg::num_master],
	input  logic                                grant_valid,
	input  logic [domain_pkg::master_w-1:0]     grant_no,
	input  logic [domain_pkg::num_master-1:0]   done,
	output logic [domain_pkg::num_master-1:0]   eligible
);
	import domain_pkg::*;

	logic                   grant_valid_q;
	logic                   start;          // New grant this cycle
	logic [num_domain-1:0]  valid;
	logic [num_domain-1:0]  stored;
	logic [num_domain-1:0]  busy;           // Block on the bus
	logic [addr_w-1:0]      base_tab [num_domain];
	logic [num_domain-1:0]  free;
	logic [entry_w-1:0]     free_no;
	logic [entry_w-1:0]     hit_no;
	logic [entry_w-1:0]     act_no;         // Entry of the running block
	logic                   act_store;
	logic                   any_hit;
	logic                   ready_hit;

	assign start = grant_valid & ~grant_valid_q;
	assign free  = ~valid;

	// Lowest free entry
	always_comb begin
		free_no = '0;
		for (int e = num_domain - 1; e >= 0; e--) begin
			if (free[e]) begin
				free_no = entry_w'(e);
			end
		end
	end

	// Stored entry the granted load reads
	always_comb begin
		hit_no = '0;
		for (int e = 0; e < num_domain; e++) begin
			if (valid[e] && stored[e] && base_tab[e] == requests[grant_no].base) begin
				hit_no = entry_w'(e);
			end
		end
	end

	////////////////////////////////////////
	// Eligibility per master
	always_comb begin
		any_hit   = 1'b0;
		ready_hit = 1'b0;
		for (int m = 0; m < num_master; m++) begin
			any_hit   = 1'b0;
			ready_hit = 1'b0;
			for (int e = 0; e < num_domain; e++) begin
				if (valid[e] && base_tab[e] == requests[m].base) begin
					any_hit = 1'b1;
					if (stored[e] && !busy[e]) begin
						ready_hit = 1'b1;
					end
				end
			end
			if (requests[m].store) begin
				eligible[m] = !any_hit && (|free);  // Base absent, room left
			end else begin
				eligible[m] = ready_hit;            // Fully stored, idle
			end
		end
	end

	////////////////////////////////////////
	// Table update
	always_ff @(posedge clock) begin
		if (reset) begin
			grant_valid_q <= 1'b0;
			valid         <= '0;
			stored        <= '0;
			busy          <= '0;
			act_no        <= '0;
			act_store     <= 1'b0;
		end else begin
			grant_valid_q <= grant_valid;
			if (start) begin
				act_store <= requests[grant_no].store;
				if (requests[grant_no].store) begin
					valid[free_no]  <= 1'b1;
					stored[free_no] <= 1'b0;
					busy[free_no]   <= 1'b1;
					act_no          <= free_no;
				end else begin
					busy[hit_no] <= 1'b1;
					act_no       <= hit_no;
				end
			end
			if (|done) begin
				if (act_store) begin
					stored[act_no] <= 1'b1;
					busy[act_no]   <= 1'b0;
				end else begin
					valid[act_no] <= 1'b0;  // Block consumed
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start && requests[grant_no].store) begin
			base_tab[free_no] <= requests[grant_no].base;
		end
	end

	// A granted store must find room in the table
	assert property (@(posedge clock) disable iff (reset)
		start && requests[grant_no].store |-> |free);

endmodule

`default_nettype wire

// ==== load_engine.sv ====
// Block load engine
`timescale 1ns/1ps
`default_nettype none

module load_engine (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        cmd_valid,
	input  logic [domain_pkg::addr_w-1:0] cmd_base,
	output logic                        cmd_ready,
	output domain_pkg::dom_req_t        request,
	input  logic                        grant,
	output domain_pkg::wb_req_t         wb_req,
	input  domain_pkg::wb_rsp_t         wb_rsp,
	output logic                        done,
	output logic                        res_valid,
	output domain_pkg::load_result_t    result
);
	import domain_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_wait,
		s_xfer
	} state_t;

	state_t             state;
	logic [cnt_w-1:0]   cnt;
	logic               stb_q;
	logic [addr_w-1:0]  base_q;
	logic [data_w-1:0]  sum_q;   // Running wrap sum

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= s_idle;
			cnt       <= '0;
			stb_q     <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= done;  // Pulse after last ack
			case (state)
				s_idle: if (cmd_valid) begin
					cnt   <= '0;
					state <= s_wait;
				end
				s_wait: if (grant) begin
					stb_q <= 1'b1;
					state <= s_xfer;
				end
				s_xfer: if (stb_q && wb_rsp.ack) begin
					stb_q <= 1'b0;
					if (cnt == cnt_w'(block_len - 1)) begin
						state <= s_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end else if (!stb_q) begin
					stb_q <= 1'b1;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_idle && cmd_valid) begin
			base_q <= cmd_base;
			sum_q  <= '0;
		end else if (state == s_xfer && stb_q && wb_rsp.ack) begin
			sum_q <= sum_q + wb_rsp.dat;
		end
	end

	assign cmd_ready       = (state == s_idle);
	assign request.pending = (state != s_idle);
	assign request.store   = 1'b0;
	assign request.base    = base_q;

	assign wb_req.cyc = (state == s_xfer);
	assign wb_req.stb = stb_q;
	assign wb_req.we  = 1'b0;
	assign wb_req.adr = base_q + addr_w'(cnt);
	assign wb_req.dat = '0;

	assign done = (state == s_xfer) & stb_q & wb_rsp.ack
		& (cnt == cnt_w'(block_len - 1));

	assign result.base = base_q;
	assign result.sum  = sum_q;

endmodule

`default_nettype wire

// ==== project.f ====
domain_pkg.sv
domain_tracker.sv
bus_arbiter.sv
store_engine.sv
load_engine.sv
shared_memory.sv
domain_top.sv
tb_domain_top.sv

// ==== shared_memory.sv ====
// Shared word memory
`timescale 1ns/1ps
`default_nettype none

module shared_memory (
	input  logic                 clock,
	input  logic                 reset,
	input  domain_pkg::wb_req_t  wb_req,
	output domain_pkg::wb_rsp_t  wb_rsp
);
	import domain_pkg::*;

	logic [data_w-1:0]  mem [2**mem_aw];
	logic               ack_q;
	logic [data_w-1:0]  rdata_q;
	logic [mem_aw-1:0]  idx;
	logic               access;  // New request seen

	assign idx    = wb_req.adr[mem_aw-1:0];
	assign access = wb_req.cyc & wb_req.stb & ~ack_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			if (wb_req.we) begin
				mem[idx] <= wb_req.dat;
			end
			rdata_q <= mem[idx];  // Returned with ack
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdata_q;

	// Master still holds its request when ack arrives
	assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

endmodule

`default_nettype wire

// ==== store_engine.sv ====
// Block store engine
`timescale 1ns/1ps
`default_nettype none

module store_engine (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    cmd_valid,
	input  domain_pkg::store_cmd_t  cmd,
	output logic                    cmd_ready,
	output domain_pkg::dom_req_t    request,
	input  logic                    grant,
	output domain_pkg::wb_req_t     wb_req,
	input  domain_pkg::wb_rsp_t     wb_rsp,
	output logic                    done
);
	import domain_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_wait,   // Waiting for grant
		s_xfer
	} state_t;

	state_t             state;
	logic [cnt_w-1:0]   cnt;      // Word index
	logic               stb_q;
	logic [addr_w-1:0]  base_q;
	logic [data_w-1:0]  seed_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= s_idle;
			cnt   <= '0;
			stb_q <= 1'b0;
		end else begin
			case (state)
				s_idle: if (cmd_valid) begin
					cnt   <= '0;
					state <= s_wait;
				end
				s_wait: if (grant) begin
					stb_q <= 1'b1;  // Grant cycle is the first gap
					state <= s_xfer;
				end
				s_xfer: if (stb_q && wb_rsp.ack) begin
					stb_q <= 1'b0;
					if (cnt == cnt_w'(block_len - 1)) begin
						state <= s_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end else if (!stb_q) begin
					stb_q <= 1'b1;  // Next word after gap
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_idle && cmd_valid) begin
			base_q <= cmd.base;
			seed_q <= cmd.seed;
		end
	end

	assign cmd_ready       = (state == s_idle);
	assign request.pending = (state != s_idle);
	assign request.store   = 1'b1;
	assign request.base    = base_q;

	assign wb_req.cyc = (state == s_xfer);
	assign wb_req.stb = stb_q;
	assign wb_req.we  = 1'b1;
	assign wb_req.adr = base_q + addr_w'(cnt);
	assign wb_req.dat = seed_q + data_w'(cnt);  // Seed plus index

	assign done = (state == s_xfer) & stb_q & wb_rsp.ack
		& (cnt == cnt_w'(block_len - 1));

endmodule

`default_nettype wire

// ==== tb_domain_top.sv ====
// Testbench for the block transfer fabric
`timescale 1ns/1ps
`default_nettype none

module tb_domain_top;
	import domain_pkg::*;

	localparam int cmd_count   = 200;              // Random commands, stores plus loads
	localparam int cycle_limit = cmd_count * 60;
	localparam int gap_cycles  = 30;               // Idle time while a load waits

	logic                   clock;
	logic                   reset;
	logic [num_engine-1:0]  store_cmd_valid;
	store_cmd_t             store_cmd [num_engine];
	logic [num_engine-1:0]  store_cmd_ready;
	logic [num_engine-1:0]  load_cmd_valid;
	logic [addr_w-1:0]      load_cmd_base [num_engine];
	logic [num_engine-1:0]  load_cmd_ready;
	logic [num_engine-1:0]  load_res_valid;
	load_result_t           load_res [num_engine];

	store_cmd_t             expected [$];      // Outstanding stores, oldest first
	int                     results_seen;
	logic [data_w-1:0]      last_sum;
	int                     cycle_count;
	int                     error_count;
	integer                 rand_seed;

	domain_top dut (
		.clock           (clock),
		.reset           (reset),
		.store_cmd_valid (store_cmd_valid),
		.store_cmd       (store_cmd),
		.store_cmd_ready (store_cmd_ready),
		.load_cmd_valid  (load_cmd_valid),
		.load_cmd_base   (load_cmd_base),
		.load_cmd_ready  (load_cmd_ready),
		.load_res_valid  (load_res_valid),
		.load_res        (load_res)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	////////////////////////////////////////
	// Reference model

	// Words are seed + 0 .. seed + 7
	function automatic logic [data_w-1:0] block_sum(input logic [data_w-1:0] seed);
		return seed * 8 + 32'd28;
	endfunction

	function automatic bit base_outstanding(input logic [addr_w-1:0] base);
		foreach (expected[i]) begin
			if (expected[i].base == base) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run("Stopping at the first mismatch");
		end
	endtask

	// Oldest store to the same base supplies the seed
	task automatic take_result(input load_result_t res);
		int idx;
		idx = -1;
		for (int i = 0; i < expected.size(); i++) begin
			if (idx < 0 && expected[i].base == res.base) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			abort_run($sformatf("Load result for base %h arrived with no store outstanding",
				res.base));
		end else begin
			check_value($sformatf("sum of base %h", res.base), res.sum,
				block_sum(expected[idx].seed));
			expected.delete(idx);
			last_sum = res.sum;
			results_seen++;
		end
	endtask

	////////////////////////////////////////
	// Result checker and cycle limit
	always @(negedge clock) begin
		if (!reset) begin
			for (int i = 0; i < num_engine; i++) begin
				if (load_res_valid[i]) begin
					take_result(load_res[i]);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
				cycle_limit));
		end
	end

	////////////////////////////////////////
	// Command drivers, called at a falling edge
	task automatic send_store(input int eng, input logic [addr_w-1:0] base,
			input logic [data_w-1:0] seed);
		while (!store_cmd_ready[eng]) begin
			@(negedge clock);
		end
		store_cmd[eng].base  = base;
		store_cmd[eng].seed  = seed;
		store_cmd_valid[eng] = 1'b1;
		@(negedge clock);
		store_cmd_valid[eng] = 1'b0;
		expected.push_back(store_cmd[eng]);  // Taken on the last rising edge
	endtask

	task automatic send_load(input int eng, input logic [addr_w-1:0] base);
		while (!load_cmd_ready[eng]) begin
			@(negedge clock);
		end
		load_cmd_base[eng]  = base;
		load_cmd_valid[eng] = 1'b1;
		@(negedge clock);
		load_cmd_valid[eng] = 1'b0;
	endtask

	task automatic wait_results(input int target);
		while (results_seen < target) begin
			@(negedge clock);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	initial begin
		int                 pick;
		int                 tries;
		int                 target;
		logic [data_w-1:0]  seed;
		logic [addr_w-1:0]  base;

		reset           = 1'b1;
		store_cmd_valid = '0;
		load_cmd_valid  = '0;
		for (int i = 0; i < num_engine; i++) begin
			store_cmd[i]     = '0;
			load_cmd_base[i] = '0;
		end
		results_seen = 0;
		last_sum     = '0;
		cycle_count  = 0;
		error_count  = 0;
		rand_seed    = 32'h3f74;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		// Idle state and a single block
		check_value("command readies after reset", {store_cmd_ready, load_cmd_ready}, 4'b1111);
		check_value("result pulses after reset", load_res_valid, '0);
		send_store(0, 16'h0010, 32'd5);
		send_load(0, 16'h0010);
		target = results_seen + 1;
		wait_results(target);
		check_value("sum of base 0010 with seed 5", last_sum, 32'd68);

		// Load ahead of its store
		send_load(1, 16'h0020);
		repeat (gap_cycles) @(negedge clock);
		check_value("waiting load engine ready", load_cmd_ready[1], 1'b0);
		send_store(1, 16'h0020, 32'h1234_5678);
		target = results_seen + 1;
		wait_results(target);

		// Same base twice, the second store must wait for the first load
		send_store(0, 16'h0028, 32'h0000_0100);
		while (!store_cmd_ready[0]) begin
			@(negedge clock);
		end
		send_load(0, 16'h0028);
		send_store(1, 16'h0028, 32'hffff_fff0);  // Sum wraps
		target = results_seen + 1;
		wait_results(target);
		check_value("second store still held", store_cmd_ready[1], 1'b0);
		send_load(1, 16'h0028);
		wait_results(target + 1);

		// Both engines of each kind at once
		send_store(0, 16'h0030, 32'h0a0a_0a0a);
		send_store(1, 16'h0038, 32'h5050_5050);
		while (store_cmd_ready != 2'b11) begin
			@(negedge clock);
		end
		send_load(0, 16'h0038);
		send_load(1, 16'h0030);
		target = results_seen + 2;
		wait_results(target);

		// Random pairs over four bases
		for (int n = 0; n < cmd_count / 2; n++) begin
			pick  = $unsigned($random(rand_seed)) % 4;
			tries = 0;
			base  = 16'h0040 + addr_w'(pick * block_len);
			while (base_outstanding(base)) begin
				pick = (pick + 1) % 4;
				tries++;
				if (tries == 4) begin
					@(negedge clock);  // All four still in flight
					tries = 0;
				end
				base = 16'h0040 + addr_w'(pick * block_len);
			end
			seed = $random(rand_seed);
			send_store($unsigned($random(rand_seed)) % num_engine, base, seed);
			send_load($unsigned($random(rand_seed)) % num_engine, base);
		end
		while (expected.size() != 0) begin
			@(negedge clock);
		end

		if (error_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			abort_run("Mismatches were recorded during the run");
		end
	end

endmodule

`default_nettype wire
